/* tb/bridge_trace.txt */
// op: 1 iread, 2 dread, 3 write, 4 dread with iread, 5 write with dread, 0 ends
// columns: op addr strb data expected_read_data
1 00000000 0 00000000 c0de0000
2 00000004 0 00000000 c0de0004
3 00000010 3 11223344 00000000
2 00000010 0 00000000 c0de3344
3 00000010 c aabbccdd 00000000
1 00000010 0 00000000 aabb3344
4 00000020 0 00000000 c0de0020
5 00000030 f 12345678 12345678
3 00000044 1 000000ee 00000000
2 00000044 0 00000000 c0de00ee
3 00000048 6 ffffffff 00000000
1 00000048 0 00000000 c0ffff48
4 00000100 0 00000000 c0de0100
5 00000104 9 87654321 87de0121
1 000003fc 0 00000000 c0de03fc
2 00000200 0 00000000 c0de0200
3 00000200 f 0badf00d 00000000
4 00000200 0 00000000 0badf00d
5 00000204 2 0000ab00 c0deab04
2 00000030 0 00000000 12345678
1 00000104 0 00000000 87de0121
4 00000044 0 00000000 c0de00ee
0 00000000 0 00000000 00000000

/* filelist.f */
source/bridge_pkg.sv
source/request_arbiter.sv
source/read_engine.sv
source/write_engine.sv
source/cache_axi_bridge.sv
tb/cache_axi_bridge_tb.sv

/* Makefile */
TOP = cache_axi_bridge_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tb/cache_axi_bridge_tb.sv */
`timescale 1ns/1ps

module cache_axi_bridge_tb import bridge_pkg::*; ();

    localparam int timeout_cycles = 200;
    localparam int idle_cycles    = 2000;

    logic aclk;
    logic aresetn;

    // cache side
    logic                      icache_rd_req_i, dcache_rd_req_i, dcache_wr_req_i;
    logic [addr_width_c-1:0]   icache_rd_addr_i, dcache_rd_addr_i, dcache_wr_addr_i;
    logic [2:0]                icache_rd_type_i, dcache_rd_type_i, dcache_wr_type_i;
    logic [data_width_c/8-1:0] dcache_wr_strb_i;
    logic [data_width_c-1:0]   dcache_wr_data_i;
    logic                      icache_rd_rdy_o, dcache_rd_rdy_o, dcache_wr_rdy_o;
    logic                      icache_ret_valid_o, dcache_ret_valid_o, dcache_wr_ok_o;
    logic [data_width_c-1:0]   icache_ret_data_o, dcache_ret_data_o;

    // AXI master side
    logic [id_width_c-1:0]     m_arid_o, m_awid_o, m_rid_i;
    logic [addr_width_c-1:0]   m_araddr_o, m_awaddr_o;
    logic [7:0]                m_arlen_o, m_awlen_o;
    logic [2:0]                m_arsize_o, m_awsize_o, m_arprot_o, m_awprot_o;
    logic [1:0]                m_arburst_o, m_awburst_o;
    logic [3:0]                m_arcache_o, m_awcache_o;
    logic                      m_arlock_o, m_awlock_o;
    logic                      m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;
    logic                      m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i;
    logic                      m_wlast_o, m_bvalid_i, m_bready_o;
    logic [data_width_c-1:0]   m_rdata_i, m_wdata_o;
    logic [data_width_c/8-1:0] m_wstrb_o;

    logic [31:0] mem [0:255];    // slave memory indexed by addr[9:2]
    logic [31:0] trace [0:159];  // five words per operation

    int          mismatches  = 0;
    int          timeouts    = 0;
    logic        aborted     = 1'b0;
    int          iret_count  = 0;
    int          dret_count  = 0;
    int          wr_ok_count = 0;
    logic [31:0] iret_data;
    logic [31:0] dret_data;
    time         iret_time, dret_time, ar_time, aw_time;

    cache_axi_bridge #(
        .ADDR_WIDTH(addr_width_c),
        .DATA_WIDTH(data_width_c)
    ) cache_axi_bridge_i (.*);

    always #10 aclk = ~aclk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL at %0t: %s expected %h got %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeouts++;
        aborted = 1'b1;
    endtask

    // raise the requests together and drop each one as it is taken
    task automatic request(input logic do_wr, input logic do_rd, input logic do_ir,
                           input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
        int   n;
        logic wr_left;
        logic rd_left;
        logic ir_left;
        @(posedge aclk);
        dcache_wr_req_i  <= do_wr;
        dcache_wr_addr_i <= addr;
        dcache_wr_strb_i <= strb;
        dcache_wr_data_i <= data;
        dcache_rd_req_i  <= do_rd;
        dcache_rd_addr_i <= addr;
        icache_rd_req_i  <= do_ir;
        icache_rd_addr_i <= addr;
        wr_left = do_wr;
        rd_left = do_rd;
        ir_left = do_ir;
        n = 0;
        while ((wr_left || rd_left || ir_left) && n < timeout_cycles) begin
            @(posedge aclk);
            n++;
            if (wr_left && dcache_wr_rdy_o) begin
                dcache_wr_req_i <= 1'b0;
                wr_left = 1'b0;
            end
            if (rd_left && dcache_rd_rdy_o) begin
                dcache_rd_req_i <= 1'b0;
                rd_left = 1'b0;
            end
            if (ir_left && icache_rd_rdy_o) begin
                icache_rd_req_i <= 1'b0;
                ir_left = 1'b0;
            end
        end
        if (wr_left || rd_left || ir_left) begin
            note_timeout("a cache request was never accepted");
            dcache_wr_req_i <= 1'b0;
            dcache_rd_req_i <= 1'b0;
            icache_rd_req_i <= 1'b0;
        end
    endtask

    task automatic wait_done(input int want_i, input int want_d, input int want_w);
        int n;
        n = 0;
        while ((iret_count < want_i || dret_count < want_d || wr_ok_count < want_w)
               && n < timeout_cycles) begin
            @(posedge aclk);
            n++;
        end
        if (iret_count < want_i || dret_count < want_d || wr_ok_count < want_w) begin
            note_timeout("a transaction never returned to its cache");
        end
    endtask

    task automatic read_slave();
        int          n;
        logic [7:0]  idx;
        logic [3:0]  id_q;
        forever begin
            n = 0;
            @(posedge aclk);
            while (!m_arvalid_o && n < idle_cycles) begin
                @(posedge aclk);
                n++;
            end
            if (!m_arvalid_o) begin
                note_timeout("no read address ever reached the slave");
            end else begin
                repeat ($urandom % 4) @(posedge aclk);
                m_arready_i <= 1'b1;
                @(posedge aclk);  // arvalid is held, so this edge is the handshake
                ar_time = $time;
                idx  = m_araddr_o[9:2];
                id_q = m_arid_o;
                check("m_arid_o", 32'(read_id_base_c[id_width_c-1:1]),
                      32'(m_arid_o[id_width_c-1:1]));
                check("m_arlen_o", 32'h0, 32'(m_arlen_o));
                check("m_arsize_o", 32'h2, 32'(m_arsize_o));
                check("m_arburst_o", 32'h1, 32'(m_arburst_o));
                check("m_arlock_o", 32'h0, 32'(m_arlock_o));
                check("m_arcache_o", 32'h0, 32'(m_arcache_o));
                check("m_arprot_o", 32'h0, 32'(m_arprot_o));
                m_arready_i <= 1'b0;
                repeat ($urandom % 4) @(posedge aclk);
                m_rid_i    <= id_q;  // echo so the bridge can route
                m_rdata_i  <= mem[idx];
                m_rvalid_i <= 1'b1;
                n = 0;
                @(posedge aclk);
                while (!m_rready_o && n < timeout_cycles) begin
                    @(posedge aclk);
                    n++;
                end
                if (!m_rready_o) note_timeout("the bridge never accepted the read data");
                m_rvalid_i <= 1'b0;
            end
        end
    endtask

    task automatic write_slave();
        int         n;
        logic [7:0] idx;
        forever begin
            n = 0;
            @(posedge aclk);
            while (!m_awvalid_o && n < idle_cycles) begin
                @(posedge aclk);
                n++;
            end
            if (!m_awvalid_o) begin
                note_timeout("no write address ever reached the slave");
            end else begin
                repeat ($urandom % 4) @(posedge aclk);
                m_awready_i <= 1'b1;
                @(posedge aclk);
                aw_time = $time;
                idx = m_awaddr_o[9:2];
                check("m_awid_o", 32'h1, 32'(m_awid_o));
                check("m_awlen_o", 32'h0, 32'(m_awlen_o));
                check("m_awsize_o", 32'h2, 32'(m_awsize_o));
                check("m_awburst_o", 32'h1, 32'(m_awburst_o));
                check("m_awlock_o", 32'h0, 32'(m_awlock_o));
                check("m_awcache_o", 32'h0, 32'(m_awcache_o));
                check("m_awprot_o", 32'h0, 32'(m_awprot_o));
                m_awready_i <= 1'b0;
                n = 0;
                @(posedge aclk);
                while (!m_wvalid_o && n < timeout_cycles) begin
                    @(posedge aclk);
                    n++;
                end
                if (!m_wvalid_o) note_timeout("write data never followed the address");
                repeat ($urandom % 4) @(posedge aclk);
                m_wready_i <= 1'b1;
                @(posedge aclk);
                check("m_wlast_o", 32'h1, 32'(m_wlast_o));
                for (int b = 0; b < 4; b++) begin
                    if (m_wstrb_o[b]) mem[idx][8*b +: 8] = m_wdata_o[8*b +: 8];
                end
                m_wready_i <= 1'b0;
                repeat ($urandom % 4) @(posedge aclk);
                m_bvalid_i <= 1'b1;
                n = 0;
                @(posedge aclk);
                while (!m_bready_o && n < timeout_cycles) begin
                    @(posedge aclk);
                    n++;
                end
                if (!m_bready_o) note_timeout("the bridge never took the write response");
                m_bvalid_i <= 1'b0;
            end
        end
    endtask

    initial begin : bus_monitor
        logic ar_pend;
        logic aw_pend;
        logic w_pend;
        ar_pend = 1'b0;
        aw_pend = 1'b0;
        w_pend  = 1'b0;
        forever begin
            @(posedge aclk);
            if (ar_pend) check("m_arvalid_o held until ready", 32'h1, 32'(m_arvalid_o));
            if (aw_pend) check("m_awvalid_o held until ready", 32'h1, 32'(m_awvalid_o));
            if (w_pend) check("m_wvalid_o held until ready", 32'h1, 32'(m_wvalid_o));
            ar_pend = m_arvalid_o & ~m_arready_i;
            aw_pend = m_awvalid_o & ~m_awready_i;
            w_pend  = m_wvalid_o & ~m_wready_i;
            if (icache_ret_valid_o) begin
                iret_count <= iret_count + 1;
                iret_data  <= icache_ret_data_o;
                iret_time  <= $time;
            end
            if (dcache_ret_valid_o) begin
                dret_count <= dret_count + 1;
                dret_data  <= dcache_ret_data_o;
                dret_time  <= $time;
            end
            if (dcache_wr_ok_o) wr_ok_count <= wr_ok_count + 1;
        end
    end

    initial begin : run_trace
        int          op_idx;
        int          base_i;
        int          base_d;
        int          base_w;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] expect_v;
        logic        do_wr;
        logic        do_rd;
        logic        do_ir;
        void'($urandom(65338));
        aclk             = 1'b0;
        aresetn          = 1'b0;
        icache_rd_req_i  = 1'b0;
        dcache_rd_req_i  = 1'b0;
        dcache_wr_req_i  = 1'b0;
        icache_rd_addr_i = '0;
        dcache_rd_addr_i = '0;
        dcache_wr_addr_i = '0;
        icache_rd_type_i = 3'd2;  // word access
        dcache_rd_type_i = 3'd2;
        dcache_wr_type_i = 3'd2;
        dcache_wr_strb_i = '0;
        dcache_wr_data_i = '0;
        m_arready_i      = 1'b0;
        m_rvalid_i       = 1'b0;
        m_rid_i          = '0;
        m_rdata_i        = '0;
        m_awready_i      = 1'b0;
        m_wready_i       = 1'b0;
        m_bvalid_i       = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hc0de, 16'(i * 4)};  // low half is the byte address
        end
        for (int i = 0; i < 160; i++) begin
            trace[i] = 32'h0;
        end
        $readmemh("tb/bridge_trace.txt", trace);
        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        fork
            read_slave();
            write_slave();
        join_none
        @(posedge aclk);
        check("icache_rd_rdy_o", 32'h1, 32'(icache_rd_rdy_o));
        check("dcache_rd_rdy_o", 32'h1, 32'(dcache_rd_rdy_o));
        check("dcache_wr_rdy_o", 32'h1, 32'(dcache_wr_rdy_o));
        check("icache_ret_valid_o", 32'h0, 32'(icache_ret_valid_o));
        check("dcache_ret_valid_o", 32'h0, 32'(dcache_ret_valid_o));
        check("dcache_wr_ok_o", 32'h0, 32'(dcache_wr_ok_o));
        check("m_arvalid_o", 32'h0, 32'(m_arvalid_o));
        check("m_awvalid_o", 32'h0, 32'(m_awvalid_o));
        check("m_wvalid_o", 32'h0, 32'(m_wvalid_o));
        check("m_rready_o", 32'h0, 32'(m_rready_o));
        check("m_bready_o", 32'h0, 32'(m_bready_o));
        op_idx = 0;
        while (op_idx < 32 && trace[op_idx * 5] != 32'h0 && !aborted) begin
            op       = trace[op_idx * 5];
            addr     = trace[op_idx * 5 + 1];
            expect_v = trace[op_idx * 5 + 4];
            do_wr    = (op == 32'd3) || (op == 32'd5);
            do_rd    = (op == 32'd2) || (op == 32'd4) || (op == 32'd5);
            do_ir    = (op == 32'd1) || (op == 32'd4);
            base_i   = iret_count;
            base_d   = dret_count;
            base_w   = wr_ok_count;
            request(do_wr, do_rd, do_ir, addr, trace[op_idx * 5 + 2][3:0],
                    trace[op_idx * 5 + 3]);
            wait_done(base_i + int'(do_ir), base_d + int'(do_rd), base_w + int'(do_wr));
            // each return pulses once, and only toward its own cache
            check("icache_ret_valid_o pulses", base_i + int'(do_ir), iret_count);
            check("dcache_ret_valid_o pulses", base_d + int'(do_rd), dret_count);
            check("dcache_wr_ok_o pulses", base_w + int'(do_wr), wr_ok_count);
            if (do_rd) check("dcache_ret_data_o", expect_v, dret_data);
            if (do_ir) check("icache_ret_data_o", expect_v, iret_data);
            if (op == 32'd4) begin
                check("data return before instruction return", 32'h1,
                      32'(dret_time < iret_time));
            end
            if (op == 32'd5) check("AW handshake before AR", 32'h1, 32'(aw_time < ar_time));
            op_idx++;
        end
        $display("operations %0d, mismatches %0d, timeouts %0d", op_idx, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* source/cache_axi_bridge.sv */
`timescale 1ns/1ps

module cache_axi_bridge import bridge_pkg::*; #(
    parameter int ADDR_WIDTH = addr_width_c,
    parameter int DATA_WIDTH = data_width_c
) (
    input  logic aclk,
    input  logic aresetn,
    // instruction cache
    input  logic icache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0] icache_rd_addr_i,
    input  logic [2:0] icache_rd_type_i,
    output logic icache_rd_rdy_o,
    output logic icache_ret_valid_o,
    output logic [DATA_WIDTH-1:0] icache_ret_data_o,
    // data cache
    input  logic dcache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0] dcache_rd_addr_i,
    input  logic [2:0] dcache_rd_type_i,
    output logic dcache_rd_rdy_o,
    output logic dcache_ret_valid_o,
    output logic [DATA_WIDTH-1:0] dcache_ret_data_o,
    input  logic dcache_wr_req_i,
    input  logic [ADDR_WIDTH-1:0] dcache_wr_addr_i,
    input  logic [2:0] dcache_wr_type_i,
    input  logic [DATA_WIDTH/8-1:0] dcache_wr_strb_i,
    input  logic [DATA_WIDTH-1:0] dcache_wr_data_i,
    output logic dcache_wr_rdy_o,
    output logic dcache_wr_ok_o,
    // AXI read address and data
    output logic [id_width_c-1:0] m_arid_o,
    output logic [ADDR_WIDTH-1:0] m_araddr_o,
    output logic [7:0] m_arlen_o,
    output logic [2:0] m_arsize_o,
    output logic [1:0] m_arburst_o,
    output logic m_arlock_o,
    output logic [3:0] m_arcache_o,
    output logic [2:0] m_arprot_o,
    output logic m_arvalid_o,
    input  logic m_arready_i,
    input  logic [id_width_c-1:0] m_rid_i,
    input  logic [DATA_WIDTH-1:0] m_rdata_i,
    input  logic m_rvalid_i,
    output logic m_rready_o,
    // AXI write address, data and response
    output logic [id_width_c-1:0] m_awid_o,
    output logic [ADDR_WIDTH-1:0] m_awaddr_o,
    output logic [7:0] m_awlen_o,
    output logic [2:0] m_awsize_o,
    output logic [1:0] m_awburst_o,
    output logic m_awlock_o,
    output logic [3:0] m_awcache_o,
    output logic [2:0] m_awprot_o,
    output logic m_awvalid_o,
    input  logic m_awready_i,
    output logic [DATA_WIDTH-1:0] m_wdata_o,
    output logic [DATA_WIDTH/8-1:0] m_wstrb_o,
    output logic m_wlast_o,
    output logic m_wvalid_o,
    input  logic m_wready_i,
    input  logic m_bvalid_i,
    output logic m_bready_o
);
    logic                    rd_start;
    logic [ADDR_WIDTH-1:0]   rd_addr;
    logic [2:0]              rd_size;
    logic                    rd_src;
    logic                    rd_done;
    logic                    wr_start;
    logic [ADDR_WIDTH-1:0]   wr_addr;
    logic [2:0]              wr_size;
    logic [DATA_WIDTH/8-1:0] wr_strb;
    logic [DATA_WIDTH-1:0]   wr_data;
    logic                    wr_done;

    // single beat, normal access
    assign m_arlen_o   = 8'd0;
    assign m_arburst_o = burst_incr_c;
    assign m_arlock_o  = 1'b0;
    assign m_arcache_o = 4'd0;
    assign m_arprot_o  = 3'd0;
    assign m_awlen_o   = 8'd0;
    assign m_awburst_o = burst_incr_c;
    assign m_awlock_o  = 1'b0;
    assign m_awcache_o = 4'd0;
    assign m_awprot_o  = 3'd0;

    request_arbiter #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) request_arbiter_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .icache_rd_req_i  (icache_rd_req_i),
        .icache_rd_addr_i (icache_rd_addr_i),
        .icache_rd_type_i (icache_rd_type_i),
        .dcache_rd_req_i  (dcache_rd_req_i),
        .dcache_rd_addr_i (dcache_rd_addr_i),
        .dcache_rd_type_i (dcache_rd_type_i),
        .dcache_wr_req_i  (dcache_wr_req_i),
        .dcache_wr_addr_i (dcache_wr_addr_i),
        .dcache_wr_type_i (dcache_wr_type_i),
        .dcache_wr_strb_i (dcache_wr_strb_i),
        .dcache_wr_data_i (dcache_wr_data_i),
        .rd_done_i        (rd_done),
        .wr_done_i        (wr_done),
        .icache_rd_rdy_o  (icache_rd_rdy_o),
        .dcache_rd_rdy_o  (dcache_rd_rdy_o),
        .dcache_wr_rdy_o  (dcache_wr_rdy_o),
        .rd_start_o       (rd_start),
        .rd_addr_o        (rd_addr),
        .rd_size_o        (rd_size),
        .rd_src_o         (rd_src),
        .wr_start_o       (wr_start),
        .wr_addr_o        (wr_addr),
        .wr_size_o        (wr_size),
        .wr_strb_o        (wr_strb),
        .wr_data_o        (wr_data)
    );

    read_engine #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) read_engine_i (
        .aclk               (aclk),
        .aresetn            (aresetn),
        .rd_start_i         (rd_start),
        .rd_addr_i          (rd_addr),
        .rd_size_i          (rd_size),
        .rd_src_i           (rd_src),
        .m_arready_i        (m_arready_i),
        .m_rid_i            (m_rid_i),
        .m_rdata_i          (m_rdata_i),
        .m_rvalid_i         (m_rvalid_i),
        .m_arid_o           (m_arid_o),
        .m_araddr_o         (m_araddr_o),
        .m_arsize_o         (m_arsize_o),
        .m_arvalid_o        (m_arvalid_o),
        .m_rready_o         (m_rready_o),
        .icache_ret_valid_o (icache_ret_valid_o),
        .icache_ret_data_o  (icache_ret_data_o),
        .dcache_ret_valid_o (dcache_ret_valid_o),
        .dcache_ret_data_o  (dcache_ret_data_o),
        .rd_done_o          (rd_done)
    );

    write_engine #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) write_engine_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .wr_start_i     (wr_start),
        .wr_addr_i      (wr_addr),
        .wr_size_i      (wr_size),
        .wr_strb_i      (wr_strb),
        .wr_data_i      (wr_data),
        .m_awready_i    (m_awready_i),
        .m_wready_i     (m_wready_i),
        .m_bvalid_i     (m_bvalid_i),
        .m_awid_o       (m_awid_o),
        .m_awaddr_o     (m_awaddr_o),
        .m_awsize_o     (m_awsize_o),
        .m_awvalid_o    (m_awvalid_o),
        .m_wdata_o      (m_wdata_o),
        .m_wstrb_o      (m_wstrb_o),
        .m_wlast_o      (m_wlast_o),
        .m_wvalid_o     (m_wvalid_o),
        .m_bready_o     (m_bready_o),
        .dcache_wr_ok_o (dcache_wr_ok_o),
        .wr_done_o      (wr_done)
    );

endmodule

/* source/write_engine.sv */
`timescale 1ns/1ps

module write_engine import bridge_pkg::*; #(
    parameter int ADDR_WIDTH = addr_width_c,
    parameter int DATA_WIDTH = data_width_c
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     wr_start_i,
    input  logic [ADDR_WIDTH-1:0]    wr_addr_i,
    input  logic [2:0]               wr_size_i,
    input  logic [DATA_WIDTH/8-1:0]  wr_strb_i,
    input  logic [DATA_WIDTH-1:0]    wr_data_i,
    input  logic                     m_awready_i,
    input  logic                     m_wready_i,
    input  logic                     m_bvalid_i,
    output logic [id_width_c-1:0]    m_awid_o,
    output logic [ADDR_WIDTH-1:0]    m_awaddr_o,
    output logic [2:0]               m_awsize_o,
    output logic                     m_awvalid_o,
    output logic [DATA_WIDTH-1:0]    m_wdata_o,
    output logic [DATA_WIDTH/8-1:0]  m_wstrb_o,
    output logic                     m_wlast_o,
    output logic                     m_wvalid_o,
    output logic                     m_bready_o,
    output logic                     dcache_wr_ok_o,
    output logic                     wr_done_o
);
    write_state_t state_q;
    logic         aw_fire;
    logic         w_fire;
    logic         b_fire;

    assign aw_fire  = m_awvalid_o & m_awready_i;
    assign w_fire   = m_wvalid_o & m_wready_i;
    assign b_fire   = m_bvalid_i & m_bready_o;
    assign m_awid_o = write_id_c;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q        <= write_idle;
            m_awvalid_o    <= 1'b0;
            m_wvalid_o     <= 1'b0;
            m_wlast_o      <= 1'b0;
            m_bready_o     <= 1'b0;
            dcache_wr_ok_o <= 1'b0;
            wr_done_o      <= 1'b0;
        end else begin
            dcache_wr_ok_o <= 1'b0;
            wr_done_o      <= 1'b0;
            case (state_q)
                write_idle: begin
                    if (wr_start_i) begin
                        m_awvalid_o <= 1'b1;
                        state_q     <= write_addr;
                    end
                end
                write_addr: begin
                    if (aw_fire) begin
                        m_awvalid_o <= 1'b0;
                        m_wvalid_o  <= 1'b1;
                        m_wlast_o   <= 1'b1;  // single beat
                        m_bready_o  <= 1'b1;
                        state_q     <= write_data;
                    end
                end
                write_data: begin
                    if (w_fire) begin
                        m_wvalid_o <= 1'b0;
                        m_wlast_o  <= 1'b0;
                        state_q    <= write_resp;
                    end
                end
                write_resp: begin
                    if (b_fire) begin
                        m_bready_o     <= 1'b0;
                        dcache_wr_ok_o <= 1'b1;
                        wr_done_o      <= 1'b1;
                        state_q        <= write_idle;
                    end
                end
                default: begin
                    state_q <= write_idle;
                end
            endcase
        end
    end

    // address, data and strobes captured once per write
    always_ff @(posedge aclk) begin
        if (state_q == write_idle && wr_start_i) begin
            m_awaddr_o <= wr_addr_i;
            m_awsize_o <= wr_size_i;
            m_wdata_o  <= wr_data_i;
            m_wstrb_o  <= wr_strb_i;
        end
    end

endmodule

/* source/read_engine.sv */
`timescale 1ns/1ps

module read_engine import bridge_pkg::*; #(
    parameter int ADDR_WIDTH = addr_width_c,
    parameter int DATA_WIDTH = data_width_c
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   rd_start_i,
    input  logic [ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic [2:0]             rd_size_i,
    input  logic                   rd_src_i,
    input  logic                   m_arready_i,
    input  logic [id_width_c-1:0]  m_rid_i,
    input  logic [DATA_WIDTH-1:0]  m_rdata_i,
    input  logic                   m_rvalid_i,
    output logic [id_width_c-1:0]  m_arid_o,
    output logic [ADDR_WIDTH-1:0]  m_araddr_o,
    output logic [2:0]             m_arsize_o,
    output logic                   m_arvalid_o,
    output logic                   m_rready_o,
    output logic                   icache_ret_valid_o,
    output logic [DATA_WIDTH-1:0]  icache_ret_data_o,
    output logic                   dcache_ret_valid_o,
    output logic [DATA_WIDTH-1:0]  dcache_ret_data_o,
    output logic                   rd_done_o
);
    read_state_t state_q;
    logic        ar_fire;
    logic        r_fire;
    logic        to_dcache;

    assign ar_fire   = m_arvalid_o & m_arready_i;
    assign r_fire    = m_rvalid_i & m_rready_o;
    assign to_dcache = (m_rid_i[0] == src_data_c);  // routing by rid bit 0

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q            <= read_idle;
            m_arvalid_o        <= 1'b0;
            m_rready_o         <= 1'b0;
            icache_ret_valid_o <= 1'b0;
            dcache_ret_valid_o <= 1'b0;
            rd_done_o          <= 1'b0;
        end else begin
            icache_ret_valid_o <= 1'b0;
            dcache_ret_valid_o <= 1'b0;
            rd_done_o          <= 1'b0;
            case (state_q)
                read_idle: begin
                    if (rd_start_i) begin
                        m_arvalid_o <= 1'b1;
                        state_q     <= read_addr;
                    end
                end
                read_addr: begin
                    if (ar_fire) begin
                        m_arvalid_o <= 1'b0;
                        m_rready_o  <= 1'b1;
                        state_q     <= read_data;
                    end
                end
                read_data: begin
                    if (r_fire) begin
                        m_rready_o         <= 1'b0;
                        icache_ret_valid_o <= ~to_dcache;
                        dcache_ret_valid_o <= to_dcache;
                        rd_done_o          <= 1'b1;
                        state_q            <= read_idle;
                    end
                end
                default: begin
                    m_arvalid_o <= 1'b0;
                    m_rready_o  <= 1'b0;
                    state_q     <= read_idle;
                end
            endcase
        end
    end

    // AR payload held until the engine is idle again
    always_ff @(posedge aclk) begin
        if (state_q == read_idle && rd_start_i) begin
            m_arid_o   <= {read_id_base_c[id_width_c-1:1], rd_src_i};
            m_araddr_o <= rd_addr_i;
            m_arsize_o <= rd_size_i;  // type code is the AXI size
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            if (to_dcache) begin
                dcache_ret_data_o <= m_rdata_i;
            end else begin
                icache_ret_data_o <= m_rdata_i;
            end
        end
    end

endmodule

/* source/request_arbiter.sv */
`timescale 1ns/1ps

module request_arbiter import bridge_pkg::*; #(
    parameter int ADDR_WIDTH = addr_width_c,
    parameter int DATA_WIDTH = data_width_c
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      icache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0]     icache_rd_addr_i,
    input  logic [2:0]                icache_rd_type_i,
    input  logic                      dcache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0]     dcache_rd_addr_i,
    input  logic [2:0]                dcache_rd_type_i,
    input  logic                      dcache_wr_req_i,
    input  logic [ADDR_WIDTH-1:0]     dcache_wr_addr_i,
    input  logic [2:0]                dcache_wr_type_i,
    input  logic [DATA_WIDTH/8-1:0]   dcache_wr_strb_i,
    input  logic [DATA_WIDTH-1:0]     dcache_wr_data_i,
    input  logic                      rd_done_i,
    input  logic                      wr_done_i,
    output logic                      icache_rd_rdy_o,
    output logic                      dcache_rd_rdy_o,
    output logic                      dcache_wr_rdy_o,
    output logic                      rd_start_o,
    output logic [ADDR_WIDTH-1:0]     rd_addr_o,
    output logic [2:0]                rd_size_o,
    output logic                      rd_src_o,
    output logic                      wr_start_o,
    output logic [ADDR_WIDTH-1:0]     wr_addr_o,
    output logic [2:0]                wr_size_o,
    output logic [DATA_WIDTH/8-1:0]   wr_strb_o,
    output logic [DATA_WIDTH-1:0]     wr_data_o
);
    logic busy_q;
    logic free;
    logic any_req;

    assign free    = ~busy_q | rd_done_i | wr_done_i;  // slot opens as the return goes out
    assign any_req = icache_rd_req_i | dcache_rd_req_i | dcache_wr_req_i;

    // write beats data read beats instruction read
    assign dcache_wr_rdy_o = free;
    assign dcache_rd_rdy_o = free & ~dcache_wr_req_i;
    assign icache_rd_rdy_o = free & ~dcache_wr_req_i & ~dcache_rd_req_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy_q     <= 1'b0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            if (free && any_req) begin
                busy_q <= 1'b1;
                if (dcache_wr_req_i) begin
                    wr_start_o <= 1'b1;
                end else begin
                    rd_start_o <= 1'b1;
                end
            end else if (rd_done_i || wr_done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // winning request payload
    always_ff @(posedge aclk) begin
        if (free) begin
            if (dcache_wr_req_i) begin
                wr_addr_o <= dcache_wr_addr_i;
                wr_size_o <= dcache_wr_type_i;
                wr_strb_o <= dcache_wr_strb_i;
                wr_data_o <= dcache_wr_data_i;
            end else if (dcache_rd_req_i) begin
                rd_addr_o <= dcache_rd_addr_i;
                rd_size_o <= dcache_rd_type_i;
                rd_src_o  <= src_data_c;
            end else begin
                rd_addr_o <= icache_rd_addr_i;
                rd_size_o <= icache_rd_type_i;
                rd_src_o  <= src_inst_c;
            end
        end
    end

endmodule

/* source/bridge_pkg.sv */
package bridge_pkg;

    // bus geometry defaults
    localparam int addr_width_c = 32;
    localparam int data_width_c = 32;
    localparam int id_width_c   = 4;

    // read id carries the requesting cache in bit 0
    localparam logic [id_width_c-1:0] read_id_base_c = 4'h2;
    localparam logic [id_width_c-1:0] write_id_c     = 4'h1;

    localparam logic src_inst_c = 1'b0;
    localparam logic src_data_c = 1'b1;

    localparam logic [1:0] burst_incr_c = 2'b01;

    typedef enum logic [1:0] {
        read_idle,
        read_addr,
        read_data  // waiting on the R beat
    } read_state_t;

    typedef enum logic [1:0] {
        write_idle,
        write_addr,
        write_data,
        write_resp
    } write_state_t;

endpackage
